/* project.f */
+incdir+rtl
rtl/tile_pkg.sv
rtl/wb_rr_arbiter.sv
rtl/wb_addr_decoder.sv
rtl/wb_sram_sp.sv
rtl/wb_bootrom.sv
rtl/compute_tile_bus.sv
verif/tile_bus_checker.sv
verif/tb_compute_tile_bus.sv

/* Bender.yml */
package:
  name: compute_tile_bus

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tile_pkg.sv
      - rtl/wb_rr_arbiter.sv
      - rtl/wb_addr_decoder.sv
      - rtl/wb_sram_sp.sv
      - rtl/wb_bootrom.sv
      - rtl/compute_tile_bus.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tile_bus_checker.sv
      - verif/tb_compute_tile_bus.sv

/* verif/tb_compute_tile_bus.sv */
// Compute tile bus testbench
`timescale 1ns/10ps
`include "tile_cfg.svh"

module tb_compute_tile_bus;

   import tile_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int RESET_CYCLES    = 10;
   localparam int NM              = `TILE_NR_MASTERS;
   localparam int NROWS           = 21;
   localparam int NCONT           = 4;            // Two rounds of two masters
   localparam int WATCHDOG_CYCLES = (NROWS + NCONT) * 40 + RESET_CYCLES;

   // One access and its expected outcome
   typedef struct packed {
      logic [1:0]  mst;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic [31:0] exp_dat;
      logic        exp_err;
   } row_t;

   logic             clk;
   logic             rst_n_i;
   wb_req_t [NM-1:0] m_req;
   wb_rsp_t [NM-1:0] m_rsp;
   wb_req_t          ext_req;
   wb_rsp_t          ext_rsp;

   row_t        rows [NROWS];
   logic [31:0] ext_mem [logic [31:0]];            // Off-tile words by word address
   int          errors;
   int          last_master;

   compute_tile_bus dut_i (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .m_req_i   (m_req),
      .m_rsp_o   (m_rsp),
      .ext_req_o (ext_req),
      .ext_rsp_i (ext_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  sel);
      logic [31:0] w;
      w = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            w[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return w;
   endfunction

   function automatic logic [31:0] rom_word(input int idx);
      return {`TILE_BOOT_TAG, 16'(idx)};
   endfunction

   task automatic abort_run(input string why);
      errors++;
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at %0t", $time);
   endtask

   task automatic load_table();
      logic [31:0] w30;
      w30 = merge_bytes(32'haaaa_aaaa, 32'h5566_7788, 4'b0101);
      rows[0]  = '{2'd0, 1'b1, 32'h0000_0010, 32'hdead_beef, 4'hf, 32'h0, 1'b0};
      rows[1]  = '{2'd1, 1'b0, 32'h0000_0010, 32'h0, 4'hf, 32'hdead_beef, 1'b0};
      rows[2]  = '{2'd1, 1'b1, 32'h0000_0020, 32'h0123_4567, 4'hf, 32'h0, 1'b0};
      rows[3]  = '{2'd0, 1'b0, 32'h0000_0420, 32'h0, 4'hf, 32'h0123_4567, 1'b0};  // Alias
      rows[4]  = '{2'd0, 1'b1, 32'h0000_0030, 32'haaaa_aaaa, 4'hf, 32'h0, 1'b0};
      rows[5]  = '{2'd1, 1'b1, 32'h0000_0030, 32'h5566_7788, 4'b0101, 32'h0, 1'b0};
      rows[6]  = '{2'd0, 1'b0, 32'h0000_0030, 32'h0, 4'hf, w30, 1'b0};
      w30 = merge_bytes(w30, 32'h1122_3344, 4'b1000);
      rows[7]  = '{2'd1, 1'b1, 32'h0000_0030, 32'h1122_3344, 4'b1000, 32'h0, 1'b0};
      rows[8]  = '{2'd1, 1'b0, 32'h0000_0030, 32'h0, 4'hf, w30, 1'b0};
      rows[9]  = '{2'd0, 1'b0, 32'hf000_0014, 32'h0, 4'hf, rom_word(5), 1'b0};
      rows[10] = '{2'd1, 1'b1, 32'hf000_0014, 32'hffff_ffff, 4'hf, 32'h0, 1'b0};
      rows[11] = '{2'd1, 1'b0, 32'hf000_0014, 32'h0, 4'hf, rom_word(5), 1'b0};
      rows[12] = '{2'd0, 1'b0, 32'hf000_003c, 32'h0, 4'hf, rom_word(15), 1'b0};
      rows[13] = '{2'd0, 1'b1, 32'he000_0100, 32'hcafe_f00d, 4'hf, 32'h0, 1'b0};
      rows[14] = '{2'd1, 1'b1, 32'he000_0104, 32'h0bad_c0de, 4'hf, 32'h0, 1'b0};
      rows[15] = '{2'd0, 1'b0, 32'he000_0100, 32'h0, 4'hf, 32'hcafe_f00d, 1'b0};
      rows[16] = '{2'd1, 1'b0, 32'he000_0104, 32'h0, 4'hf, 32'h0bad_c0de, 1'b0};
      rows[17] = '{2'd0, 1'b0, 32'h9000_0000, 32'h0, 4'hf, 32'h0, 1'b1};          // Unmapped
      rows[18] = '{2'd1, 1'b1, 32'ha000_0008, 32'h1234_5678, 4'hf, 32'h0, 1'b1};
      rows[19] = '{2'd0, 1'b0, 32'h0000_0010, 32'h0, 4'hf, 32'hdead_beef, 1'b0};
      rows[20] = '{2'd0, 1'b0, 32'he000_0100, 32'h0, 4'hf, 32'hcafe_f00d, 1'b0};
   endtask

   // One single-beat access, held until ack or err
   task automatic run_access(input int m, input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output wb_rsp_t rsp, output int lat);
      @(negedge clk);
      m_req[m] = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
      lat = 0;
      do begin
         @(posedge clk);
         #1;
         lat++;
         rsp = m_rsp[m];
      end while (!rsp.ack && !rsp.err);
      @(negedge clk);
      m_req[m] = '0;
   endtask

   task automatic check_idle();
      for (int m = 0; m < NM; m++) begin
         assert (!m_rsp[m].ack && !m_rsp[m].err) else
            abort_run($sformatf("MISMATCH at %0t: master %0d answered after reset", $time, m));
      end
      assert (!ext_req.cyc && !ext_req.stb) else
         abort_run($sformatf("MISMATCH at %0t: external port active after reset", $time));
   endtask

   task automatic check_row(input int i, input wb_rsp_t rsp, input int lat, input bit chk_lat);
      if (rows[i].exp_err) begin
         assert (rsp.err && !rsp.ack) else
            abort_run($sformatf("MISMATCH at %0t: row %0d expected err, got ack=%b err=%b",
                                $time, i, rsp.ack, rsp.err));
      end else begin
         assert (rsp.ack && !rsp.err) else
            abort_run($sformatf("MISMATCH at %0t: row %0d expected ack, got ack=%b err=%b",
                                $time, i, rsp.ack, rsp.err));
         if (!rows[i].we) begin
            assert (rsp.dat == rows[i].exp_dat) else
               abort_run($sformatf("MISMATCH at %0t: row %0d read %h, expected %h",
                                   $time, i, rsp.dat, rows[i].exp_dat));
         end
      end
      if (chk_lat) begin
         assert (lat == 2) else
            abort_run($sformatf("MISMATCH at %0t: row %0d answered after %0d cycles, expected 2",
                                $time, i, lat));
      end
   endtask

   // Both masters request data memory in the same cycle
   task automatic contend(input logic we);
      wb_rsp_t     rsp_c [NM];
      int          lat_c [NM];
      time         done_t [NM];
      logic [31:0] adr_c [NM];
      logic [31:0] exp_c [NM];
      int          first;
      int          second;
      first    = (last_master + 1) % NM;
      second   = (first + 1) % NM;
      adr_c[0] = we ? 32'h0000_0080 : 32'h0000_0084;  // Reads cross over
      adr_c[1] = we ? 32'h0000_0084 : 32'h0000_0080;
      exp_c[0] = 32'h1b1b_1b1b;
      exp_c[1] = 32'h0a0a_0a0a;
      fork
         begin
            run_access(0, we, adr_c[0], 32'h0a0a_0a0a, 4'hf, rsp_c[0], lat_c[0]);
            done_t[0] = $time;
         end
         begin
            run_access(1, we, adr_c[1], 32'h1b1b_1b1b, 4'hf, rsp_c[1], lat_c[1]);
            done_t[1] = $time;
         end
      join
      assert (done_t[first] < done_t[second]) else
         abort_run($sformatf("MISMATCH at %0t: master %0d was not served first", $time, first));
      for (int m = 0; m < NM; m++) begin
         assert (rsp_c[m].ack && !rsp_c[m].err) else
            abort_run($sformatf("MISMATCH at %0t: master %0d got no clean ack", $time, m));
         if (!we) begin
            assert (rsp_c[m].dat == exp_c[m]) else
               abort_run($sformatf("MISMATCH at %0t: master %0d read %h, expected %h",
                                   $time, m, rsp_c[m].dat, exp_c[m]));
         end
      end
      last_master = second;
   endtask

   // External memory with 0 to 3 extra cycles of latency
   initial begin : ext_model
      logic        seen;
      logic        busy;
      wb_req_t     cur;
      int unsigned wait_cnt;
      logic [31:0] key;
      logic [31:0] old_w;
      void'($urandom(32'h95ab_ea44));
      busy     = 1'b0;
      wait_cnt = 0;
      forever begin
         @(posedge clk);
         #1;
         seen = ext_req.cyc && ext_req.stb;
         cur  = ext_req;
         @(negedge clk);
         if (ext_rsp.ack) begin
            ext_rsp = '0;                          // Single-cycle ack
         end else if (seen) begin
            if (!busy) begin
               busy     = 1'b1;
               wait_cnt = $urandom % 4;
            end
            if (wait_cnt == 0) begin
               busy  = 1'b0;
               key   = cur.adr >> 2;
               old_w = ext_mem.exists(key) ? ext_mem[key] : 32'h0;
               if (cur.we) begin
                  ext_mem[key] = merge_bytes(old_w, cur.dat, cur.sel);
               end
               ext_rsp = '{ack: 1'b1, err: 1'b0, dat: old_w};
            end else begin
               wait_cnt--;
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES));
   end

   // Bus protocol violations seen by the bound checker
   always @(negedge clk) begin
      if (dut_i.u_checker.fail_cnt != 0) begin
         abort_run("Protocol checker flagged a bus violation");
      end
   end

   initial begin : main
      wb_rsp_t rsp;
      int      lat;
      bit      internal;
      errors      = 0;
      last_master = NM - 1;
      rst_n_i     = 1'b0;
      m_req       = '0;
      ext_rsp     = '0;
      load_table();
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n_i = 1'b1;
      @(posedge clk);
      #1;
      check_idle();
      for (int i = 0; i < NROWS; i++) begin
         run_access(int'(rows[i].mst), rows[i].we, rows[i].adr, rows[i].dat, rows[i].sel,
                    rsp, lat);
         internal = (rows[i].adr[31:28] != `TILE_EXT_NIBBLE);  // Fixed latency only on-tile
         check_row(i, rsp, lat, internal);
         last_master = int'(rows[i].mst);
      end
      contend(1'b1);
      contend(1'b0);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* verif/tile_bus_checker.sv */
// Bus protocol assertions
`timescale 1ns/10ps
`include "tile_cfg.svh"

module tile_bus_checker (
   input logic                                     clk,
   input logic                                     rst_n_i,
   input tile_pkg::wb_rsp_t [`TILE_NR_MASTERS-1:0] m_rsp_i
);

   logic [`TILE_NR_MASTERS-1:0] answered;
   int unsigned                 fail_cnt = 0;      // Assertion failures so far

   always_comb begin
      for (int m = 0; m < `TILE_NR_MASTERS; m++) begin
         answered[m] = m_rsp_i[m].ack | m_rsp_i[m].err;
      end
   end

   for (genvar m = 0; m < `TILE_NR_MASTERS; m++) begin : gen_master
      ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
         !(m_rsp_i[m].ack && m_rsp_i[m].err))
         else begin
            fail_cnt++;
            $error("Master %0d got ack and err together", m);
         end
   end

   one_answer: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(answered))
      else begin
         fail_cnt++;
         $error("More than one master answered in one cycle");
      end

   // First cycle out of reset stays quiet
   quiet_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> answered == '0)
      else begin
         fail_cnt++;
         $error("Response seen right after reset release");
      end

endmodule

bind compute_tile_bus tile_bus_checker u_checker (
   .clk     (clk),
   .rst_n_i (rst_n_i),
   .m_rsp_i (m_rsp_o)
);

/* rtl/compute_tile_bus.sv */
// Compute tile bus fabric
`timescale 1ns/10ps
`include "tile_cfg.svh"

module compute_tile_bus (
   input  logic                                     clk,
   input  logic                                     rst_n_i,
   input  tile_pkg::wb_req_t [`TILE_NR_MASTERS-1:0] m_req_i,
   output tile_pkg::wb_rsp_t [`TILE_NR_MASTERS-1:0] m_rsp_o,
   output tile_pkg::wb_req_t                        ext_req_o,
   input  tile_pkg::wb_rsp_t                        ext_rsp_i
);

   import tile_pkg::*;

   wb_req_t bus_req;                            // Owner's request
   wb_rsp_t bus_rsp;
   wb_req_t dm_req;
   wb_rsp_t dm_rsp;
   wb_req_t boot_req;
   wb_rsp_t boot_rsp;

   wb_rr_arbiter u_arbiter (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .m_req_i   (m_req_i),
      .m_rsp_o   (m_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   wb_addr_decoder u_decoder (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .bus_req_i  (bus_req),
      .bus_rsp_o  (bus_rsp),
      .dm_req_o   (dm_req),
      .dm_rsp_i   (dm_rsp),
      .boot_req_o (boot_req),
      .boot_rsp_i (boot_rsp),
      .ext_req_o  (ext_req_o),                  // Window e goes off-tile
      .ext_rsp_i  (ext_rsp_i)
   );

   wb_sram_sp u_dm (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (dm_req),
      .rsp_o   (dm_rsp)
   );

   wb_bootrom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (boot_req),
      .rsp_o   (boot_rsp)
   );

endmodule

/* rtl/wb_bootrom.sv */
// Boot ROM
`timescale 1ns/10ps
`include "tile_cfg.svh"

module wb_bootrom (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   import tile_pkg::*;

   localparam int AW = $clog2(`TILE_BOOT_WORDS);

   logic [31:0] rom [`TILE_BOOT_WORDS];
   logic [31:0] rdata_q;
   logic        ack_q;
   logic        access;

   // Tag in the upper half, word index in the lower half
   for (genvar w = 0; w < `TILE_BOOT_WORDS; w++) begin : gen_rom
      assign rom[w] = {`TILE_BOOT_TAG, 16'(w)};
   end

   assign access = req_i.cyc & req_i.stb & ~ack_q;

   always_ff @(posedge clk) begin
      if (access) begin
         rdata_q <= rom[req_i.adr[AW+1:2]];     // Writes only get the ack
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};

endmodule

/* rtl/wb_sram_sp.sv */
// Local data memory
`timescale 1ns/10ps
`include "tile_cfg.svh"

module wb_sram_sp (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   import tile_pkg::*;

   localparam int AW = $clog2(`TILE_DM_WORDS);

   logic [31:0]   mem [`TILE_DM_WORDS];
   logic [AW-1:0] word_idx;
   logic [31:0]   rdata_q;
   logic          ack_q;
   logic          access;

   assign word_idx = req_i.adr[AW+1:2];         // Higher address bits alias
   assign access   = req_i.cyc & req_i.stb & ~ack_q;

   // Byte-lane writes and registered read
   always_ff @(posedge clk) begin
      if (access) begin
         if (req_i.we) begin
            for (int b = 0; b < 4; b++) begin
               if (req_i.sel[b]) begin
                  mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
         rdata_q <= mem[word_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;                       // One cycle per access
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;
   assign rsp_o.dat = rdata_q;

endmodule

/* rtl/wb_addr_decoder.sv */
// Bus address decoder
`timescale 1ns/10ps
`include "tile_cfg.svh"

module wb_addr_decoder (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t bus_req_i,
   output tile_pkg::wb_rsp_t bus_rsp_o,
   output tile_pkg::wb_req_t dm_req_o,
   input  tile_pkg::wb_rsp_t dm_rsp_i,
   output tile_pkg::wb_req_t boot_req_o,
   input  tile_pkg::wb_rsp_t boot_rsp_i,
   output tile_pkg::wb_req_t ext_req_o,
   input  tile_pkg::wb_rsp_t ext_rsp_i
);

   import tile_pkg::*;

   target_e tgt;
   logic    err_q;
   logic    access;

   assign access = bus_req_i.cyc & bus_req_i.stb;

   always_comb begin
      if (!bus_req_i.adr[31]) begin
         tgt = TGT_DM;                          // Lower half of the map
      end else if (bus_req_i.adr[31:28] == `TILE_EXT_NIBBLE) begin
         tgt = TGT_EXT;
      end else if (bus_req_i.adr[31:28] == `TILE_BOOT_NIBBLE) begin
         tgt = TGT_BOOT;
      end else begin
         tgt = TGT_NONE;
      end
   end

   // Payload goes everywhere, handshake only to the selected slave
   always_comb begin
      dm_req_o       = bus_req_i;
      dm_req_o.cyc   = bus_req_i.cyc & (tgt == TGT_DM);
      dm_req_o.stb   = bus_req_i.stb & (tgt == TGT_DM);
      boot_req_o     = bus_req_i;
      boot_req_o.cyc = bus_req_i.cyc & (tgt == TGT_BOOT);
      boot_req_o.stb = bus_req_i.stb & (tgt == TGT_BOOT);
      ext_req_o      = bus_req_i;
      ext_req_o.cyc  = bus_req_i.cyc & (tgt == TGT_EXT);
      ext_req_o.stb  = bus_req_i.stb & (tgt == TGT_EXT);
   end

   // Single-cycle error for unmapped accesses
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= access & (tgt == TGT_NONE) & ~err_q;
      end
   end

   always_comb begin
      case (tgt)
         TGT_DM:   bus_rsp_o = dm_rsp_i;
         TGT_BOOT: bus_rsp_o = boot_rsp_i;
         TGT_EXT:  bus_rsp_o = ext_rsp_i;
         default:  bus_rsp_o = '{ack: 1'b0, err: err_q, dat: '0};
      endcase
   end

endmodule

/* rtl/wb_rr_arbiter.sv */
// Round-robin bus arbiter
`timescale 1ns/10ps
`include "tile_cfg.svh"

module wb_rr_arbiter (
   input  logic                                     clk,
   input  logic                                     rst_n_i,
   input  tile_pkg::wb_req_t [`TILE_NR_MASTERS-1:0] m_req_i,
   output tile_pkg::wb_rsp_t [`TILE_NR_MASTERS-1:0] m_rsp_o,
   output tile_pkg::wb_req_t                        bus_req_o,
   input  tile_pkg::wb_rsp_t                        bus_rsp_i
);

   import tile_pkg::*;

   localparam int NM = `TILE_NR_MASTERS;
   localparam int IW = $clog2(NM);

   arb_state_e  state;
   logic [IW-1:0] owner;
   logic [IW-1:0] last_owner;
   logic [IW-1:0] pick;
   logic          any_cyc;

   // Search starts just after the last owner
   always_comb begin
      int unsigned cand;
      pick    = last_owner;
      any_cyc = 1'b0;
      for (int k = 1; k <= NM; k++) begin
         cand = (int'(last_owner) + k) % NM;
         if (!any_cyc && m_req_i[cand].cyc) begin
            pick    = IW'(cand);
            any_cyc = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state      <= ARB_IDLE;
         owner      <= '0;
         last_owner <= IW'(NM - 1);             // Master 0 wins first
      end else begin
         case (state)
            ARB_IDLE: if (any_cyc) begin
               state <= ARB_OWNED;
               owner <= pick;
            end
            ARB_OWNED: if (!m_req_i[owner].cyc) begin
               state      <= ARB_IDLE;          // Released one cycle after cyc drops
               last_owner <= owner;
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   assign bus_req_o = (state == ARB_OWNED) ? m_req_i[owner] : '0;

   // Only the owner sees the response
   always_comb begin
      for (int m = 0; m < NM; m++) begin
         if (state == ARB_OWNED && owner == IW'(m)) begin
            m_rsp_o[m] = bus_rsp_i;
         end else begin
            m_rsp_o[m] = '0;
         end
      end
   end

endmodule

/* rtl/tile_pkg.sv */
// Compute tile bus types
package tile_pkg;

   // Master to slave
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] adr;
      logic [31:0] dat;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef enum logic {
      ARB_IDLE,
      ARB_OWNED
   } arb_state_e;

   // Decoded slave of the current access
   typedef enum logic [1:0] {
      TGT_DM,
      TGT_BOOT,
      TGT_EXT,
      TGT_NONE
   } target_e;

endpackage

/* rtl/tile_cfg.svh */
// Compute tile bus configuration
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Bus masters, instruction and data port stand-ins
`define TILE_NR_MASTERS 2

// Local data memory, 32-bit words, wraps within its window
`define TILE_DM_WORDS 256

// Boot ROM, 32-bit words
`define TILE_BOOT_WORDS 16

// Upper half of every boot ROM word
`define TILE_BOOT_TAG 16'hb007

// Top address nibbles of the upper windows
`define TILE_EXT_NIBBLE 4'he
`define TILE_BOOT_NIBBLE 4'hf

`endif
